// ==== include/softmax_cfg.svh ====
// Softmax front end configuration
// Lane count, datapath widths, FIFO depth and credit limits

`ifndef SOFTMAX_CFG_SVH
`define SOFTMAX_CFG_SVH

// Lanes per input beat
`define SMX_LANES 4

// Signed score and Q1.15 exponential widths
`define SMX_SCORE_W 8
`define SMX_EXP_W 16

// Vector sum carries two growth bits over one exponential
`define SMX_SUM_W (`SMX_EXP_W + 2)
`define SMX_ACC_W 24

// Input FIFO slots, equal to the credits the source starts with
`define SMX_FIFO_DEPTH 4

// Output credits owned by the sink at reset
`define SMX_OUT_CREDITS 4
`define SMX_CNT_W 3

`endif

// ==== design/softmax_pkg.sv ====
// Softmax front end types
// Packed beat formats passed between the pipeline stages

`default_nettype none

`include "softmax_cfg.svh"

package softmax_pkg;

    typedef logic signed [`SMX_SCORE_W-1:0] score_t;

    // Max rise between beats, capped at 31
    typedef logic [4:0] delta_t;

    typedef struct packed {
        score_t [`SMX_LANES-1:0] score;
        logic   [`SMX_LANES-1:0] strb;
    } score_beat_t;

    typedef struct packed {
        score_beat_t beat;
        score_t      max;
        delta_t      delta;
    } max_beat_t;

    // Q1.15 exponentials, 1.0 is 0x8000
    typedef struct packed {
        logic [`SMX_LANES-1:0][`SMX_EXP_W-1:0] exp;
        logic [`SMX_LANES-1:0]                 strb;
    } exp_beat_t;

    typedef struct packed {
        logic [`SMX_SUM_W-1:0] sum;
        delta_t                delta;
    } sum_beat_t;

endpackage

`default_nettype wire

// ==== design/score_ingress.sv ====
// Score ingress
// Input FIFO with credit return to the source, and the output credit
// counter that decides when a beat may enter the pipeline

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module score_ingress (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      in_valid_i,
    input  wire softmax_pkg::score_beat_t  in_beat_i,
    input  wire logic                      out_credit_i,
    output logic                           in_credit_o,
    output logic                           issue_valid_o,
    output softmax_pkg::score_beat_t       issue_beat_o,
    output logic                           pending_o
);

    localparam int unsigned PTR_W = $clog2(`SMX_FIFO_DEPTH);

    softmax_pkg::score_beat_t fifo_mem [`SMX_FIFO_DEPTH];

    // Extra wrap bit tells full from empty
    logic [PTR_W:0]          wr_ptr_q;
    logic [PTR_W:0]          rd_ptr_q;
    logic [`SMX_CNT_W-1:0]   credit_q;
    logic                    empty;
    logic                    pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign pop   = ~empty & (credit_q != '0);

    assign in_credit_o = pop;
    assign pending_o   = ~empty;

    // Source holds a credit for every push, so no overflow check
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            fifo_mem[wr_ptr_q[PTR_W-1:0]] <= in_beat_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
            credit_q      <= `SMX_CNT_W'(`SMX_OUT_CREDITS);
            issue_valid_o <= 1'b0;
        end else begin
            if (in_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({pop, out_credit_i})
                2'b10:   credit_q <= credit_q - 1'b1;
                2'b01:   credit_q <= credit_q + 1'b1;
                default: credit_q <= credit_q;
            endcase
            issue_valid_o <= pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            issue_beat_o <= fifo_mem[rd_ptr_q[PTR_W-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== design/score_max_tracker.sv ====
// Running maximum tracker
// First stage, merges the largest strobed lane into the running max
// and tags the beat with the new max and the capped rise

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module score_max_tracker (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      clear_i,
    input  wire logic                      valid_i,
    input  wire softmax_pkg::score_beat_t  beat_i,
    output logic                           valid_o,
    output softmax_pkg::max_beat_t         beat_o,
    output logic signed [`SMX_SCORE_W-1:0] max_o
);

    localparam softmax_pkg::score_t MIN_SCORE = {1'b1, {(`SMX_SCORE_W-1){1'b0}}};

    softmax_pkg::score_t    max_q;
    softmax_pkg::score_t    beat_max;
    softmax_pkg::score_t    new_max;
    logic [`SMX_SCORE_W:0]  rise;
    softmax_pkg::delta_t    delta;

    // Unstrobed lanes never take part
    always_comb begin
        beat_max = MIN_SCORE;
        for (int i = 0; i < `SMX_LANES; i++) begin
            if (beat_i.strb[i] && (beat_i.score[i] > beat_max)) begin
                beat_max = beat_i.score[i];
            end
        end
    end

    assign new_max = (beat_max > max_q) ? beat_max : max_q;
    assign rise    = {new_max[`SMX_SCORE_W-1], new_max} - {max_q[`SMX_SCORE_W-1], max_q};
    assign delta   = (rise > 31) ? 5'd31 : rise[4:0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            max_q   <= MIN_SCORE;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (clear_i) begin
                max_q <= MIN_SCORE;
            end else if (valid_i) begin
                max_q <= new_max;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            beat_o.beat  <= beat_i;
            beat_o.max   <= new_max;
            beat_o.delta <= delta;
        end
    end

    assign max_o = max_q;

endmodule

`default_nettype wire

// ==== design/exp_lane_array.sv ====
// Lane exponential array
// Second stage, each lane gives 2^(score - max) in Q1.15 by a right shift

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module exp_lane_array (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     valid_i,
    input  wire softmax_pkg::max_beat_t   beat_i,
    output logic                          valid_o,
    output softmax_pkg::exp_beat_t        beat_o,
    output softmax_pkg::delta_t           delta_o
);

    localparam logic [`SMX_EXP_W-1:0] EXP_ONE = {1'b1, {(`SMX_EXP_W-1){1'b0}}};

    logic [`SMX_LANES-1:0][`SMX_SCORE_W:0]  diff;
    softmax_pkg::exp_beat_t                 exp_d;

    always_comb begin
        for (int i = 0; i < `SMX_LANES; i++) begin
            diff[i] = {beat_i.max[`SMX_SCORE_W-1], beat_i.max}
                    - {beat_i.beat.score[i][`SMX_SCORE_W-1], beat_i.beat.score[i]};
            // Differences of 16 or more underflow Q1.15
            if (beat_i.beat.strb[i] && (diff[i][`SMX_SCORE_W:4] == '0)) begin
                exp_d.exp[i] = EXP_ONE >> diff[i][3:0];
            end else begin
                exp_d.exp[i] = '0;
            end
        end
        exp_d.strb = beat_i.beat.strb;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            beat_o  <= exp_d;
            delta_o <= beat_i.delta;
        end
    end

endmodule

`default_nettype wire

// ==== design/lane_sum_tree.sv ====
// Lane reduction sum
// Third stage, two-level adder tree over the exponential lanes

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module lane_sum_tree (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     valid_i,
    input  wire softmax_pkg::exp_beat_t   beat_i,
    input  wire softmax_pkg::delta_t      delta_i,
    output logic                          valid_o,
    output softmax_pkg::sum_beat_t        sum_o
);

    localparam int unsigned PAIRS = `SMX_LANES / 2;

    logic [PAIRS-1:0][`SMX_EXP_W:0] pair_sum;
    logic [`SMX_SUM_W-1:0]          total;

    always_comb begin
        total = '0;
        for (int p = 0; p < PAIRS; p++) begin
            pair_sum[p] = {1'b0, beat_i.exp[2*p]} + {1'b0, beat_i.exp[2*p+1]};
            total       = total + `SMX_SUM_W'(pair_sum[p]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            sum_o.sum   <= total;
            sum_o.delta <= delta_i;
        end
    end

endmodule

`default_nettype wire

// ==== design/denom_accumulator.sv ====
// Denominator accumulator
// Rescales the running sum by the max rise, then adds the new vector sum
// with saturation

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module denom_accumulator (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic                     clear_i,
    input  wire logic                     valid_i,
    input  wire softmax_pkg::sum_beat_t   sum_i,
    output logic [`SMX_ACC_W-1:0]         denom_o
);

    logic [`SMX_ACC_W-1:0] acc_q;
    logic [`SMX_ACC_W-1:0] scaled;
    logic [`SMX_ACC_W:0]   acc_sum;

    // Old terms lose one bit per unit of max rise
    assign scaled  = acc_q >> sum_i.delta;
    assign acc_sum = {1'b0, scaled} + (`SMX_ACC_W + 1)'(sum_i.sum);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (valid_i) begin
            if (acc_sum[`SMX_ACC_W]) begin
                acc_q <= '1;
            end else begin
                acc_q <= acc_sum[`SMX_ACC_W-1:0];
            end
        end
    end

    assign denom_o = acc_q;

endmodule

`default_nettype wire

// ==== design/softmax_top.sv ====
// Streaming softmax front end
// Credit-flow ingress, running max, lane exponentials, vector sum and
// the rescaled denominator accumulator

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module softmax_top (
    input  wire logic                      clk_i,
    input  wire logic                      rst_ni,
    input  wire logic                      clear_i,
    input  wire logic                      in_valid_i,
    input  wire softmax_pkg::score_beat_t  in_beat_i,
    output logic                           in_credit_o,
    input  wire logic                      out_credit_i,
    output logic                           out_valid_o,
    output softmax_pkg::exp_beat_t         out_beat_o,
    output logic signed [`SMX_SCORE_W-1:0] max_o,
    output logic [`SMX_ACC_W-1:0]          denom_o,
    output logic                           busy_o
);

    logic                      pending;
    logic                      issue_valid;
    softmax_pkg::score_beat_t  issue_beat;
    logic                      max_valid;
    softmax_pkg::max_beat_t    max_beat;
    softmax_pkg::delta_t       exp_delta;
    logic                      sum_valid;
    softmax_pkg::sum_beat_t    sum_beat;

    assign busy_o = pending | issue_valid | max_valid | out_valid_o | sum_valid;

    score_ingress i_ingress (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .in_valid_i    (in_valid_i),
        .in_beat_i     (in_beat_i),
        .out_credit_i  (out_credit_i),
        .in_credit_o   (in_credit_o),
        .issue_valid_o (issue_valid),
        .issue_beat_o  (issue_beat),
        .pending_o     (pending)
    );

    score_max_tracker i_max (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (issue_valid),
        .beat_i  (issue_beat),
        .valid_o (max_valid),
        .beat_o  (max_beat),
        .max_o   (max_o)
    );

    exp_lane_array i_exp (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (max_valid),
        .beat_i  (max_beat),
        .valid_o (out_valid_o),
        .beat_o  (out_beat_o),
        .delta_o (exp_delta)
    );

    lane_sum_tree i_sum (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .valid_i (out_valid_o),
        .beat_i  (out_beat_o),
        .delta_i (exp_delta),
        .valid_o (sum_valid),
        .sum_o   (sum_beat)
    );

    denom_accumulator i_acc (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .valid_i (sum_valid),
        .sum_i   (sum_beat),
        .denom_o (denom_o)
    );

endmodule

`default_nettype wire

// ==== tb/softmax_assert.sv ====
// Softmax front end assertions
// Credit accounting on both stream ends and output state in reset

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module softmax_assert (
    input wire logic clk_i,
    input wire logic rst_ni,
    input wire logic in_valid_i,
    input wire logic in_credit_i,
    input wire logic out_credit_i,
    input wire logic out_valid_i
);

    int unsigned beats_in_q;
    int unsigned credits_back_q;
    int unsigned outs_q;
    int unsigned granted_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beats_in_q     <= 0;
            credits_back_q <= 0;
            outs_q         <= 0;
            granted_q      <= `SMX_OUT_CREDITS;
        end else begin
            if (in_valid_i) begin
                beats_in_q <= beats_in_q + 1;
            end
            if (in_credit_i) begin
                credits_back_q <= credits_back_q + 1;
            end
            if (out_valid_i) begin
                outs_q <= outs_q + 1;
            end
            if (out_credit_i) begin
                granted_q <= granted_q + 1;
            end
        end
    end

    // A credit goes back only for a beat already in the FIFO
    credit_return_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_credit_i |-> (credits_back_q < beats_in_q))
        else $error("input credit returned with no matching beat");

    out_credit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_i |-> (outs_q < granted_q))
        else $error("output beat issued beyond granted credits");

    reset_quiet_a: assert property (@(posedge clk_i) !rst_ni |-> !out_valid_i)
        else $error("output valid high during reset");

endmodule

bind softmax_top softmax_assert i_assert (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_credit_i  (in_credit_o),
    .out_credit_i (out_credit_i),
    .out_valid_i  (out_valid_o)
);

`default_nettype wire

// ==== tb/tb_softmax.sv ====
// Softmax front end testbench
// Credit-driven source and sink, reference model of max, exponentials and
// denominator, and checks on every output beat

`timescale 1ns/1ps
`default_nettype none

`include "softmax_cfg.svh"

module tb_softmax;

    localparam int LANES      = `SMX_LANES;
    localparam int ACC_MAX    = (1 << `SMX_ACC_W) - 1;
    localparam int WAIT_LIMIT = 400;

    logic                           clk;
    logic                           rst_n;
    logic                           clear;
    logic                           in_valid;
    softmax_pkg::score_beat_t       in_beat;
    logic                           in_credit;
    logic                           out_credit;
    logic                           out_valid;
    softmax_pkg::exp_beat_t         out_beat;
    logic signed [`SMX_SCORE_W-1:0] max_val;
    logic [`SMX_ACC_W-1:0]          denom;
    logic                           busy;

    int  src_credits;
    int  sink_owed;
    int  sink_granted;
    int  beats_seen;
    int  sink_cycle;
    bit  stall_mode;

    // Reference state advances as output beats are compared
    int  ref_max;
    int  ref_den;

    softmax_pkg::score_beat_t sent_q[$];

    softmax_top UUT (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .clear_i      (clear),
        .in_valid_i   (in_valid),
        .in_beat_i    (in_beat),
        .in_credit_o  (in_credit),
        .out_credit_i (out_credit),
        .out_valid_o  (out_valid),
        .out_beat_o   (out_beat),
        .max_o        (max_val),
        .denom_o      (denom),
        .busy_o       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_stop();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input logic [127:0] got, input logic [127:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
            fail_stop();
        end
    endtask

    // Max, 2^(score - max) in Q1.15 and the rescaled denominator
    function automatic softmax_pkg::exp_beat_t model_beat(
        input  softmax_pkg::score_beat_t beat,
        input  int                       max_in,
        input  int                       den_in,
        output int                       max_out,
        output int                       den_out
    );
        softmax_pkg::exp_beat_t res;
        int m;
        int rise;
        int diff;
        int lane_exp;
        int sum;
        int acc;
        m = max_in;
        for (int i = 0; i < LANES; i++) begin
            if (beat.strb[i] && int'($signed(beat.score[i])) > m) begin
                m = int'($signed(beat.score[i]));
            end
        end
        rise = (m - max_in > 31) ? 31 : m - max_in;
        sum  = 0;
        for (int i = 0; i < LANES; i++) begin
            diff     = m - int'($signed(beat.score[i]));
            lane_exp = (beat.strb[i] && diff < 16) ? (32768 >> diff) : 0;
            res.exp[i] = `SMX_EXP_W'(lane_exp);
            sum += lane_exp;
        end
        res.strb = beat.strb;
        acc      = (den_in >> rise) + sum;
        max_out  = m;
        den_out  = (acc > ACC_MAX) ? ACC_MAX : acc;
        return res;
    endfunction

    function automatic softmax_pkg::score_beat_t rand_beat(input int lo, input int hi,
                                                           input bit full);
        softmax_pkg::score_beat_t beat;
        for (int i = 0; i < LANES; i++) begin
            beat.score[i] = `SMX_SCORE_W'(lo + int'($urandom_range(hi - lo)));
        end
        beat.strb = full ? '1 : LANES'($urandom_range((1 << LANES) - 1));
        return beat;
    endfunction

    always @(negedge clk) begin : compare_out
        softmax_pkg::score_beat_t beat;
        softmax_pkg::exp_beat_t   expected;
        int                       new_max;
        int                       new_den;
        if (rst_n && out_valid) begin
            if (sent_q.size() == 0) begin
                $display("Output beat arrived with no input beat outstanding");
                fail_stop();
            end else begin
                beat     = sent_q.pop_front();
                expected = model_beat(beat, ref_max, ref_den, new_max, new_den);
                ref_max  = new_max;
                ref_den  = new_den;
                check_value(128'(out_beat), 128'(expected), "exponential beat");
                beats_seen++;
                sink_owed++;
                check_value(128'(beats_seen <= sink_granted), 128'(1),
                            "output beats within granted credits");
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && in_credit) begin
            src_credits++;
            check_value(128'(src_credits <= `SMX_FIFO_DEPTH), 128'(1),
                        "source credits within FIFO depth");
        end
    end

    // Sink returns credits after a random delay and holds them in long stalls when asked
    initial begin : credit_sink
        bit hold;
        out_credit   = 1'b0;
        sink_owed    = 0;
        sink_granted = `SMX_OUT_CREDITS;
        sink_cycle   = 0;
        forever begin
            @(posedge clk);
            #1;
            sink_cycle++;
            hold = stall_mode && ((sink_cycle % 50) < 40);
            if (rst_n && sink_owed > 0 && !hold && $urandom_range(3) == 0) begin
                out_credit = 1'b1;
                sink_owed--;
                sink_granted++;
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic send_beat(input softmax_pkg::score_beat_t beat);
        int waited;
        waited = 0;
        while (src_credits == 0) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: source got no input credit back in %0d cycles", WAIT_LIMIT);
                fail_stop();
            end
            waited++;
            step();
        end
        src_credits--;
        sent_q.push_back(beat);
        in_valid = 1'b1;
        in_beat  = beat;
        step();
        in_valid = 1'b0;
    endtask

    task automatic drain_check(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            if (waited >= WAIT_LIMIT) begin
                $display("Timeout: pipeline still busy after %0d cycles (%s)", WAIT_LIMIT, what);
                fail_stop();
            end
            waited++;
            @(negedge clk);
        end
        check_value(128'(sent_q.size()), 128'(0), {what, ", beats outstanding"});
        check_value(128'(int'(max_val)), 128'(ref_max), {what, ", running max"});
        check_value(128'(denom), 128'(ref_den), {what, ", denominator"});
        step();
    endtask

    task automatic pulse_clear();
        clear = 1'b1;
        step();
        clear   = 1'b0;
        ref_max = -128;
        ref_den = 0;
        @(negedge clk);
        check_value(128'(int'(max_val)), 128'(-128), "max after clear");
        check_value(128'(denom), 128'(0), "denominator after clear");
        step();
    endtask

    task automatic ascending_scores();
        softmax_pkg::score_beat_t beat;
        for (int k = 0; k < 16; k++) begin
            beat.strb = '1;
            for (int i = 0; i < LANES; i++) begin
                beat.score[i] = `SMX_SCORE_W'(-20 + 3 * k + i);
            end
            send_beat(beat);
            // First half drains after every beat and the rest goes back to back
            if (k < 8) begin
                drain_check("ascending single beat");
            end
        end
        drain_check("ascending burst");
    endtask

    task automatic partial_strobes();
        softmax_pkg::score_beat_t beat;
        // Differences of 0, 15, 16 and 17 around the new max
        beat.score = {8'sd23, 8'sd24, 8'sd25, 8'sd40};
        beat.strb  = 4'b1111;
        send_beat(beat);
        beat.score = {8'sd100, -8'sd30, 8'sd127, 8'sd10};
        beat.strb  = 4'b0101;
        send_beat(beat);
        beat.strb  = 4'b0000;
        send_beat(beat);
        drain_check("partial strobes");
        for (int k = 0; k < 12; k++) begin
            send_beat(rand_beat(-128, 127, 1'b0));
        end
        drain_check("random partial strobes");
    endtask

    task automatic saturate_denominator();
        softmax_pkg::score_beat_t beat;
        pulse_clear();
        beat.score = '0;
        beat.strb  = '1;
        // Enough unit beats to reach saturation
        for (int k = 0; k < 136; k++) begin
            send_beat(beat);
        end
        drain_check("saturated denominator");
        beat.score = {4{8'sd3}};
        send_beat(beat);
        for (int k = 0; k < 24; k++) begin
            send_beat(rand_beat(-8, 8, 1'b0));
        end
        drain_check("rescaled denominator");
    endtask

    task automatic stall_sink();
        stall_mode = 1'b1;
        for (int k = 0; k < 24; k++) begin
            send_beat(rand_beat(-16, 16, 1'b0));
        end
        stall_mode = 1'b0;
        drain_check("sink back-pressure");
    endtask

    task automatic clear_and_restart();
        for (int k = 0; k < 6; k++) begin
            send_beat(rand_beat(-40, 40, 1'b1));
        end
        drain_check("sequence before clear");
        pulse_clear();
        for (int k = 0; k < 10; k++) begin
            send_beat(rand_beat(-60, 20, 1'b0));
        end
        drain_check("sequence after clear");
    endtask

    initial begin : stimulus
        void'($urandom(4));
        rst_n       = 1'b0;
        clear       = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        stall_mode  = 1'b0;
        src_credits = `SMX_FIFO_DEPTH;
        beats_seen  = 0;
        ref_max     = -128;
        ref_den     = 0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value(128'(out_valid), 128'(0), "out_valid after reset");
        check_value(128'(in_credit), 128'(0), "in_credit after reset");
        check_value(128'(busy), 128'(0), "busy after reset");
        check_value(128'(int'(max_val)), 128'(-128), "max after reset");
        check_value(128'(denom), 128'(0), "denominator after reset");
        step();
        ascending_scores();
        partial_strobes();
        saturate_denominator();
        stall_sink();
        clear_and_restart();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
design/softmax_pkg.sv
design/score_ingress.sv
design/score_max_tracker.sv
design/exp_lane_array.sv
design/lane_sum_tree.sv
design/denom_accumulator.sv
design/softmax_top.sv
tb/softmax_assert.sv
tb/tb_softmax.sv

// ==== run.sh ====
#!/bin/sh
# Builds the softmax testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_softmax -o Vtb_softmax

# A stopped run still leaves its log for the checks below
./obj_dir/Vtb_softmax > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
